// ==== verilog/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Reservation station depth, also the credit count after reset
`define RS_SIZE 8

// Physical tag width and the register count it addresses
`define TAG_W 4
`define NUM_REGS (1 << `TAG_W)

// Datapath width
`define XLEN 32

// Issue lanes, one ALU and one CDB lane each
`define ISSUE_W 2

// Opcode field width
`define OP_W 4

// Credit return width, enough for 0 to ISSUE_W freed entries
`define CREDIT_W 2

`endif

// ==== verilog/ooo_pkg.sv ====
`include "ooo_cfg.svh"

package ooo_pkg;

    // Age counter wide enough to saturate above the station depth
    localparam int AGE_W = $clog2(`RS_SIZE) + 1;

    typedef enum logic [`OP_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,
        // Load immediate into dst
        OP_LI
    } alu_op_e;

    // One reservation station slot
    typedef struct packed {
        logic              full;
        alu_op_e           op;
        logic [`TAG_W-1:0] dst;
        logic [`TAG_W-1:0] src1;
        logic              src1_rdy;
        logic [`TAG_W-1:0] src2;
        logic              src2_rdy;
        logic [`XLEN-1:0]  imm;
        // Dispatches seen since this entry was written
        logic [AGE_W-1:0]  age;
    } rs_entry_t;

endpackage

// ==== verilog/reservation_station.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reservation_station (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_valid,
    input  ooo_pkg::alu_op_e      disp_op,
    input  logic [`TAG_W-1:0]     disp_dst,
    input  logic [`TAG_W-1:0]     disp_src1,
    input  logic                  disp_src1_rdy,
    input  logic [`TAG_W-1:0]     disp_src2,
    input  logic                  disp_src2_rdy,
    input  logic [`XLEN-1:0]      disp_imm,
    input  logic                  cdb_valid [`ISSUE_W],
    input  logic [`TAG_W-1:0]     cdb_tag [`ISSUE_W],
    output logic                  issue_valid [`ISSUE_W],
    output ooo_pkg::alu_op_e      issue_op [`ISSUE_W],
    output logic [`TAG_W-1:0]     issue_dst [`ISSUE_W],
    output logic [`TAG_W-1:0]     issue_src1 [`ISSUE_W],
    output logic [`TAG_W-1:0]     issue_src2 [`ISSUE_W],
    output logic [`XLEN-1:0]      issue_imm [`ISSUE_W],
    output logic [`CREDIT_W-1:0]  credit_return
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`RS_SIZE);
    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    rs_entry_t          entries [`RS_SIZE];
    rs_entry_t          entries_nxt [`RS_SIZE];
    rs_entry_t          new_entry;
    logic               entry_rdy [`RS_SIZE];
    logic               free_found;
    logic [IDX_W-1:0]   free_idx;
    logic               disp_fire;
    logic               sel_valid [`ISSUE_W];
    logic [IDX_W-1:0]   sel_idx [`ISSUE_W];
    logic [`CREDIT_W-1:0] freed_cnt;

    // Lowest free slot takes the dispatched op
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int j = 0; j < `RS_SIZE; j++) begin
            if (!entries[j].full && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(j);
            end
        end
    end

    assign disp_fire = disp_valid && free_found;

    // Incoming op, with sources woken by a broadcast in the same cycle
    always_comb begin
        new_entry.full     = 1'b1;
        new_entry.op       = disp_op;
        new_entry.dst      = disp_dst;
        new_entry.src1     = disp_src1;
        new_entry.src1_rdy = disp_src1_rdy;
        new_entry.src2     = disp_src2;
        new_entry.src2_rdy = disp_src2_rdy;
        new_entry.imm      = disp_imm;
        new_entry.age      = '0;
        for (int l = 0; l < `ISSUE_W; l++) begin
            if (cdb_valid[l] && cdb_tag[l] == disp_src1) begin
                new_entry.src1_rdy = 1'b1;
            end
            if (cdb_valid[l] && cdb_tag[l] == disp_src2) begin
                new_entry.src2_rdy = 1'b1;
            end
        end
    end

    always_comb begin
        for (int j = 0; j < `RS_SIZE; j++) begin
            entry_rdy[j] = entries[j].full && entries[j].src1_rdy && entries[j].src2_rdy;
        end
    end

    // Oldest ready entry per lane, ties go to the lower index
    always_comb begin
        logic taken;
        taken = 1'b0;
        for (int l = 0; l < `ISSUE_W; l++) begin
            sel_valid[l] = 1'b0;
            sel_idx[l]   = '0;
        end
        for (int l = 0; l < `ISSUE_W; l++) begin
            for (int j = 0; j < `RS_SIZE; j++) begin
                taken = 1'b0;
                for (int k = 0; k < l; k++) begin
                    if (sel_valid[k] && sel_idx[k] == IDX_W'(j)) begin
                        taken = 1'b1;
                    end
                end
                if (entry_rdy[j] && !taken &&
                    (!sel_valid[l] || entries[j].age > entries[sel_idx[l]].age)) begin
                    sel_valid[l] = 1'b1;
                    sel_idx[l]   = IDX_W'(j);
                end
            end
        end
    end

    // Next entry state: wakeup, aging, issue and write
    always_comb begin
        entries_nxt = entries;
        for (int j = 0; j < `RS_SIZE; j++) begin
            if (entries[j].full) begin
                for (int l = 0; l < `ISSUE_W; l++) begin
                    if (cdb_valid[l] && cdb_tag[l] == entries[j].src1) begin
                        entries_nxt[j].src1_rdy = 1'b1;
                    end
                    if (cdb_valid[l] && cdb_tag[l] == entries[j].src2) begin
                        entries_nxt[j].src2_rdy = 1'b1;
                    end
                end
                if (disp_fire && entries[j].age != AGE_MAX) begin
                    entries_nxt[j].age = entries[j].age + 1'b1;
                end
            end
        end
        for (int l = 0; l < `ISSUE_W; l++) begin
            if (sel_valid[l]) begin
                entries_nxt[sel_idx[l]].full = 1'b0;
            end
        end
        if (disp_fire) begin
            entries_nxt[free_idx] = new_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < `RS_SIZE; j++) begin
                entries[j].full <= 1'b0;
            end
        end else begin
            entries <= entries_nxt;
        end
    end

    always_comb begin
        freed_cnt = '0;
        for (int l = 0; l < `ISSUE_W; l++) begin
            freed_cnt = freed_cnt + `CREDIT_W'(sel_valid[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_return <= '0;
            for (int l = 0; l < `ISSUE_W; l++) begin
                issue_valid[l] <= 1'b0;
            end
        end else begin
            credit_return <= freed_cnt;
            for (int l = 0; l < `ISSUE_W; l++) begin
                issue_valid[l] <= sel_valid[l];
            end
        end
    end

    // Issue payload
    always_ff @(posedge clk) begin
        for (int l = 0; l < `ISSUE_W; l++) begin
            if (sel_valid[l]) begin
                issue_op[l]   <= entries[sel_idx[l]].op;
                issue_dst[l]  <= entries[sel_idx[l]].dst;
                issue_src1[l] <= entries[sel_idx[l]].src1;
                issue_src2[l] <= entries[sel_idx[l]].src2;
                issue_imm[l]  <= entries[sel_idx[l]].imm;
            end
        end
    end

endmodule

// ==== verilog/phys_reg_file.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module phys_reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic [`TAG_W-1:0] rd_tag [2*`ISSUE_W],
    input  logic              cdb_valid [`ISSUE_W],
    input  logic [`TAG_W-1:0] cdb_tag [`ISSUE_W],
    input  logic [`XLEN-1:0]  cdb_data [`ISSUE_W],
    output logic [`XLEN-1:0]  rd_data [2*`ISSUE_W]
);

    // Two source reads per issue lane
    localparam int RD_PORTS = 2 * `ISSUE_W;

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // Both CDB lanes write at the edge; lanes never share a tag
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < `ISSUE_W; l++) begin
                if (cdb_valid[l]) begin
                    regs[cdb_tag[l]] <= cdb_data[l];
                end
            end
        end
    end

    // Reads see the value written at the previous edge,
    // wakeup lags the broadcast by one cycle so no bypass
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_data[p] = regs[rd_tag[p]];
        end
    end

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ooo_pkg::alu_op_e  issue_op,
    input  logic [`TAG_W-1:0] issue_dst,
    input  logic [`XLEN-1:0]  issue_imm,
    input  logic [`XLEN-1:0]  src1_data,
    input  logic [`XLEN-1:0]  src2_data,
    output logic              cdb_valid,
    output logic [`TAG_W-1:0] cdb_tag,
    output logic [`XLEN-1:0]  cdb_data
);
    import ooo_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic              s1_valid;
    alu_op_e           s1_op;
    logic [`TAG_W-1:0] s1_dst;
    logic [`XLEN-1:0]  s1_a;
    logic [`XLEN-1:0]  s1_b;
    logic [`XLEN-1:0]  s1_imm;
    logic [`XLEN-1:0]  result;

    // Stage 1 captures the op and the register file operands
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op  <= issue_op;
        s1_dst <= issue_dst;
        s1_a   <= src1_data;
        s1_b   <= src2_data;
        s1_imm <= issue_imm;
    end

    always_comb begin
        case (s1_op)
            OP_ADD:  result = s1_a + s1_b;
            OP_SUB:  result = s1_a - s1_b;
            OP_AND:  result = s1_a & s1_b;
            OP_OR:   result = s1_a | s1_b;
            OP_XOR:  result = s1_a ^ s1_b;
            OP_SLL:  result = s1_a << s1_b[SHAMT_W-1:0];
            OP_SRL:  result = s1_a >> s1_b[SHAMT_W-1:0];
            // Signed compare, result is 0 or 1
            OP_SLT:  result = `XLEN'($signed(s1_a) < $signed(s1_b));
            OP_LI:   result = s1_imm;
            default: result = '0;
        endcase
    end

    // Stage 2 drives the CDB lane
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= s1_dst;
        cdb_data <= result;
    end

endmodule

// ==== verilog/ooo_issue_top.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_issue_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 disp_valid,
    input  ooo_pkg::alu_op_e     disp_op,
    input  logic [`TAG_W-1:0]    disp_dst,
    input  logic [`TAG_W-1:0]    disp_src1,
    input  logic                 disp_src1_rdy,
    input  logic [`TAG_W-1:0]    disp_src2,
    input  logic                 disp_src2_rdy,
    input  logic [`XLEN-1:0]     disp_imm,
    output logic [`CREDIT_W-1:0] credit_return,
    output logic                 cdb_valid [`ISSUE_W],
    output logic [`TAG_W-1:0]    cdb_tag [`ISSUE_W],
    output logic [`XLEN-1:0]     cdb_data [`ISSUE_W]
);
    import ooo_pkg::*;

    logic              issue_valid [`ISSUE_W];
    alu_op_e           issue_op [`ISSUE_W];
    logic [`TAG_W-1:0] issue_dst [`ISSUE_W];
    logic [`TAG_W-1:0] issue_src1 [`ISSUE_W];
    logic [`TAG_W-1:0] issue_src2 [`ISSUE_W];
    logic [`XLEN-1:0]  issue_imm [`ISSUE_W];
    logic [`TAG_W-1:0] rd_tag [2*`ISSUE_W];
    logic [`XLEN-1:0]  rd_data [2*`ISSUE_W];

    reservation_station u_rs (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_dst      (disp_dst),
        .disp_src1     (disp_src1),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2     (disp_src2),
        .disp_src2_rdy (disp_src2_rdy),
        .disp_imm      (disp_imm),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_dst     (issue_dst),
        .issue_src1    (issue_src1),
        .issue_src2    (issue_src2),
        .issue_imm     (issue_imm),
        .credit_return (credit_return)
    );

    phys_reg_file u_prf (
        .clk       (clk),
        .rst       (rst),
        .rd_tag    (rd_tag),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .rd_data   (rd_data)
    );

    // Lane l reads src1 on port 2l and src2 on port 2l+1
    for (genvar l = 0; l < `ISSUE_W; l++) begin : g_lane
        assign rd_tag[2*l]   = issue_src1[l];
        assign rd_tag[2*l+1] = issue_src2[l];

        alu_unit u_alu (
            .clk         (clk),
            .rst         (rst),
            .issue_valid (issue_valid[l]),
            .issue_op    (issue_op[l]),
            .issue_dst   (issue_dst[l]),
            .issue_imm   (issue_imm[l]),
            .src1_data   (rd_data[2*l]),
            .src2_data   (rd_data[2*l+1]),
            .cdb_valid   (cdb_valid[l]),
            .cdb_tag     (cdb_tag[l]),
            .cdb_data    (cdb_data[l])
        );
    end

endmodule

// ==== bench/ooo_checker.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exp_valid,
    input  logic [`TAG_W-1:0]    exp_tag,
    input  logic [`XLEN-1:0]     exp_data,
    input  logic                 cdb_valid [`ISSUE_W],
    input  logic [`TAG_W-1:0]    cdb_tag [`ISSUE_W],
    input  logic [`XLEN-1:0]     cdb_data [`ISSUE_W],
    output logic [`NUM_REGS-1:0] seen,
    output logic [`NUM_REGS-1:0] pending,
    output int                   errors,
    output int                   lane_hits [`ISSUE_W]
);

    logic [`XLEN-1:0] expected [`NUM_REGS];

    initial begin
        errors = 0;
        for (int l = 0; l < `ISSUE_W; l++) begin
            lane_hits[l] = 0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            seen    <= '0;
            pending <= '0;
        end else begin
            for (int l = 0; l < `ISSUE_W; l++) begin
                if (cdb_valid[l]) begin
                    lane_hits[l] = lane_hits[l] + 1;
                    if (!pending[cdb_tag[l]]) begin
                        $display("CDB lane %0d broadcast tag %0d with no result outstanding",
                                 l, cdb_tag[l]);
                        errors = errors + 1;
                    end else if (cdb_data[l] !== expected[cdb_tag[l]]) begin
                        $display("[ERROR] cdb_data tag 0x%h expected 0x%h actual 0x%h",
                                 cdb_tag[l], expected[cdb_tag[l]], cdb_data[l]);
                        errors = errors + 1;
                    end
                    pending[cdb_tag[l]] <= 1'b0;
                    seen[cdb_tag[l]]    <= 1'b1;
                end
            end
            // A new expectation rearms its tag for this group
            if (exp_valid) begin
                expected[exp_tag] <= exp_data;
                pending[exp_tag]  <= 1'b1;
                seen[exp_tag]     <= 1'b0;
            end
        end
    end

endmodule

// ==== bench/ooo_asserts.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic [`CREDIT_W-1:0] credit_return,
    input logic                 issue_valid [`ISSUE_W],
    input logic                 cdb_valid [`ISSUE_W],
    input logic [`TAG_W-1:0]    cdb_tag [`ISSUE_W]
);

    int fail_cnt = 0;

    a_credit_max: assert property (@(posedge clk) disable iff (rst) credit_return != 2'd3)
        else begin $error("credit_return equals 3"); fail_cnt++; end

    a_cdb_tags: assert property (@(posedge clk) disable iff (rst)
        (cdb_valid[0] && cdb_valid[1]) |-> (cdb_tag[0] != cdb_tag[1]))
        else begin $error("both CDB lanes carry one tag"); fail_cnt++; end

    // Two pipeline stages from issue to broadcast
    a_lane0_lat: assert property (@(posedge clk) disable iff (rst)
        issue_valid[0] |-> ##2 cdb_valid[0])
        else begin $error("lane 0 result missing two cycles after issue"); fail_cnt++; end

    a_lane1_lat: assert property (@(posedge clk) disable iff (rst)
        issue_valid[1] |-> ##2 cdb_valid[1])
        else begin $error("lane 1 result missing two cycles after issue"); fail_cnt++; end

endmodule

bind ooo_issue_top ooo_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .credit_return (credit_return),
    .issue_valid   (issue_valid),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag)
);

// ==== bench/tb_ooo_issue.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module tb_ooo_issue;
    import ooo_pkg::*;

    localparam int REC_W    = 8;
    localparam int MAX_RECS = 64;
    localparam int TIMEOUT  = 300;

    logic                  clk;
    logic                  rst;
    logic                  disp_valid;
    alu_op_e               disp_op;
    logic [`TAG_W-1:0]     disp_dst;
    logic [`TAG_W-1:0]     disp_src1;
    logic                  disp_src1_rdy;
    logic [`TAG_W-1:0]     disp_src2;
    logic                  disp_src2_rdy;
    logic [`XLEN-1:0]      disp_imm;
    logic [`CREDIT_W-1:0]  credit_return;
    logic                  cdb_valid [`ISSUE_W];
    logic [`TAG_W-1:0]     cdb_tag [`ISSUE_W];
    logic [`XLEN-1:0]      cdb_data [`ISSUE_W];
    logic                  exp_valid;
    logic [`TAG_W-1:0]     exp_tag;
    logic [`XLEN-1:0]      exp_data;
    logic [`NUM_REGS-1:0]  seen;
    logic [`NUM_REGS-1:0]  pending;
    int                    chk_errors;
    int                    lane_hits [`ISSUE_W];
    logic [31:0]           data_mem [REC_W*MAX_RECS];
    logic [31:0]           lfsr;
    int                    credits;
    int                    failed;
    int                    passed;
    bit                    test_ok;

    ooo_issue_top i_dut (.*);

    ooo_checker u_checker (.*, .errors(chk_errors));

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Dispatcher credit count refilled by credit_return
    always @(posedge clk) begin
        if (rst) begin
            credits <= `RS_SIZE;
        end else begin
            credits <= credits + int'(credit_return) - (disp_valid ? 1 : 0);
        end
    end

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    task automatic send_op(input int rec, input bit gaps);
        int base;
        int cnt;
        int gap;
        base = rec * REC_W;
        cnt  = 0;
        while (credits == 0 && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (credits == 0) begin
            $display("dispatch timed out waiting for a credit");
            test_ok = 1'b0;
            return;
        end
        disp_op       = alu_op_e'(data_mem[base][`OP_W-1:0]);
        disp_dst      = data_mem[base+1][`TAG_W-1:0];
        disp_src1     = data_mem[base+2][`TAG_W-1:0];
        disp_src2     = data_mem[base+4][`TAG_W-1:0];
        // A source already broadcast in this group counts as ready
        disp_src1_rdy = data_mem[base+3][0] | seen[disp_src1];
        disp_src2_rdy = data_mem[base+5][0] | seen[disp_src2];
        disp_imm      = data_mem[base+6];
        exp_tag       = disp_dst;
        exp_data      = data_mem[base+7];
        disp_valid    = 1'b1;
        exp_valid     = 1'b1;
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        exp_valid  = 1'b0;
        if (gaps) begin
            gap = take_bits(2);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic reset_midway();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        // Registered outputs clear at the first reset edge and stay clear
        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            #1;
            if (credit_return != '0) begin
                $display("[ERROR] credit_return 0x%h expected 0x0 in reset", credit_return);
                test_ok = 1'b0;
            end
            for (int l = 0; l < `ISSUE_W; l++) begin
                if (cdb_valid[l]) begin
                    $display("[ERROR] cdb_valid lane %0d 0x1 expected 0x0 in reset", l);
                    test_ok = 1'b0;
                end
            end
        end
        rst = 1'b0;
    endtask

    initial begin
        int rec;
        int first;
        int count;
        int flags;
        int errs_before;
        int lane1_before;
        int cnt;
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_op = OP_ADD;
        disp_dst = '0;
        disp_src1 = '0;
        disp_src1_rdy = 1'b0;
        disp_src2 = '0;
        disp_src2_rdy = 1'b0;
        disp_imm = '0;
        exp_valid = 1'b0;
        exp_tag = '0;
        exp_data = '0;
        lfsr = 32'hcb7b;
        failed = 0;
        passed = 0;
        $readmemh("bench/ooo_testdata.hex", data_mem);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        rec = 0;
        while (rec < MAX_RECS && data_mem[rec*REC_W][3:0] == 4'he) begin
            flags = int'(data_mem[rec*REC_W+1]);
            first = rec + 1;
            count = 0;
            while (data_mem[(first+count)*REC_W][3:0] < 4'he) begin
                count++;
            end
            test_ok = 1'b1;
            if (flags[1]) begin
                for (int i = 0; i < count && i < 3; i++) begin
                    send_op(first + i, 1'b1);
                end
                reset_midway();
            end
            errs_before  = chk_errors;
            lane1_before = lane_hits[1];
            for (int i = 0; i < count; i++) begin
                send_op(first + i, !flags[0]);
            end
            cnt = 0;
            while (pending != '0 && cnt < TIMEOUT) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (pending != '0) begin
                $display("test %0d timed out waiting for its results", passed + failed + 1);
                test_ok = 1'b0;
            end
            if (credits != `RS_SIZE) begin
                $display("[ERROR] credits 0x%h expected 0x%h", credits, `RS_SIZE);
                test_ok = 1'b0;
            end
            if (flags[2] && lane_hits[1] == lane1_before) begin
                $display("second CDB lane never carried a result");
                test_ok = 1'b0;
            end
            if (chk_errors != errs_before) begin
                test_ok = 1'b0;
            end
            if (test_ok) begin
                passed++;
                $display("test %0d: %0d ops, pass", passed + failed, count);
            end else begin
                failed++;
                $display("test %0d: %0d ops, FAIL", passed + failed, count);
            end
            rec = first + count;
        end
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 passed + failed, passed, failed, i_dut.u_asserts.fail_cnt);
        if (failed == 0 && passed > 0 && i_dut.u_asserts.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/ooo_pkg.sv
verilog/reservation_station.sv
verilog/phys_reg_file.sv
verilog/alu_unit.sv
verilog/ooo_issue_top.sv
bench/ooo_checker.sv
bench/ooo_asserts.sv
bench/tb_ooo_issue.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_ooo_issue -o sim_ooo

# Assertion errors must not abort the run, the testbench counts them
./obj_dir/sim_ooo +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed"
    exit 1
fi

// ==== bench/ooo_testdata.hex ====
// Header: E flags 0 0 0 0 0 0 (flags bit0 no gaps, bit1 reset midway, bit2 needs lane 1)
// Record: op dst src1 src1_rdy src2 src2_rdy imm expected
E 0 0 0 0 0 0 0
8 1 0 1 0 1 11111111 11111111
8 2 0 1 0 1 0000abcd 0000abcd
8 3 0 1 0 1 deadbeef deadbeef
8 4 0 1 0 1 80000000 80000000
E 0 0 0 0 0 0 0
8 1 0 1 0 1 fffffff6 fffffff6
8 2 0 1 0 1 00000023 00000023
0 3 1 0 2 0 0 00000019
1 4 1 0 2 0 0 ffffffd3
2 5 1 0 2 0 0 00000022
3 6 1 0 2 0 0 fffffff7
4 7 1 0 2 0 0 ffffffd5
5 8 1 0 2 0 0 ffffffb0
6 9 1 0 2 0 0 1ffffffe
7 a 1 0 2 0 0 00000001
7 b 2 0 1 0 0 00000000
E 0 0 0 0 0 0 0
8 1 0 1 0 1 00000005 00000005
0 2 1 0 1 0 0 0000000a
0 3 2 0 1 0 0 0000000f
0 4 3 0 3 0 0 0000001e
5 5 4 0 1 0 0 000003c0
4 6 5 0 4 0 0 000003de
E 1 0 0 0 0 0 0
8 1 0 1 0 1 00000001 00000001
0 2 1 0 1 0 0 00000002
0 3 2 0 2 0 0 00000004
0 4 3 0 3 0 0 00000008
1 5 3 0 3 0 0 00000000
3 6 3 0 3 0 0 00000004
2 7 3 0 3 0 0 00000004
4 8 3 0 3 0 0 00000000
5 9 3 0 3 0 0 00000040
6 a 3 0 3 0 0 00000000
7 b 3 0 3 0 0 00000000
0 c 3 0 3 0 0 00000008
E 5 0 0 0 0 0 0
8 1 0 1 0 1 00000064 00000064
0 2 1 0 1 0 0 000000c8
0 3 2 0 2 0 0 00000190
1 4 2 0 1 0 0 00000064
4 5 2 0 1 0 0 000000ac
3 6 2 0 1 0 0 000000ec
2 7 2 0 1 0 0 00000040
E 2 0 0 0 0 0 0
8 1 0 1 0 1 cafef00d cafef00d
8 2 0 1 0 1 12345678 12345678
0 3 1 0 2 0 0 dd334685
1 4 3 0 2 0 0 cafef00d
F 0 0 0 0 0 0 0
